// ==== hdl/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath sizes
`define CPU_WORD_W      32
`define CPU_NUM_REGS    8
`define CPU_IMEM_DEPTH  64
`define CPU_IMM_W       16

// Instruction field positions
`define CPU_IMM_FLAG_BIT 31
`define CPU_KIND_MSB     30
`define CPU_KIND_LSB     29
`define CPU_OP_MSB       28
`define CPU_OP_LSB       26
`define CPU_RS1_MSB      21
`define CPU_RS1_LSB      19
`define CPU_RS2_MSB      18
`define CPU_RS2_LSB      16

`endif

// ==== hdl/cpu_pkg.sv ====
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [`CPU_WORD_W-1:0] instr_t;

  typedef logic [$clog2(`CPU_NUM_REGS)-1:0]   reg_idx_t;
  typedef logic [$clog2(`CPU_IMEM_DEPTH)-1:0] imem_addr_t;

  // Bit 0 lower half, bit 1 upper half
  typedef logic [1:0] half_en_t;

  // Instruction type field
  typedef enum logic [1:0] {
    KIND_NONE       = 2'b00,
    KIND_ARITH_MOVE = 2'b01,
    KIND_MEMORY     = 2'b10, // decoded as no-op
    KIND_AUDIO      = 2'b11  // decoded as no-op
  } instr_kind_t;

  // Operation field shared by arithmetic and move
  typedef enum logic [2:0] {
    OP_NONE = 3'b000,
    OP_ADD  = 3'b001,
    OP_INC  = 3'b011,
    OP_MOVL = 3'b101,
    OP_MOVU = 3'b110,
    OP_MOVR = 3'b111
  } alu_op_t;

  // Where the writeback value comes from
  typedef enum logic [1:0] {
    SRC_NONE = 2'b00,
    SRC_ALU  = 2'b01,
    SRC_OPND = 2'b10
  } wb_src_t;

endpackage

`default_nettype wire

// ==== hdl/instr_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module instr_memory (
  input  logic                clk,
  input  logic                load_strobe,
  input  cpu_pkg::imem_addr_t load_addr,
  input  cpu_pkg::instr_t     load_data,
  input  cpu_pkg::imem_addr_t rd_addr,
  output cpu_pkg::instr_t     rd_data
);
  import cpu_pkg::*;

  instr_t mem [`CPU_IMEM_DEPTH];

  // Loaded by the host while run is low
  always_ff @(posedge clk) begin
    if (load_strobe) begin
      mem[load_addr] <= load_data;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr]; // one cycle read
  end

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module fetch_stage (
  input  logic                clk,
  input  logic                resetn,
  input  logic                run,
  input  logic                stall,
  input  logic                load_strobe,
  input  cpu_pkg::imem_addr_t load_addr,
  input  cpu_pkg::instr_t     load_data,
  output cpu_pkg::instr_t     instr
);
  import cpu_pkg::*;

  imem_addr_t pc;
  instr_t     rd_data;
  logic       rd_valid;     // rd_data holds a word not yet passed on
  instr_t     replay;       // word caught while stalled
  logic       replay_valid;
  logic       advance;

  assign advance = run && !stall;

  instr_memory u_instr_memory (
    .clk        (clk),
    .load_strobe(load_strobe),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .rd_addr    (pc),
    .rd_data    (rd_data)
  );

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      pc       <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= advance;
      if (advance) begin
        if (pc == imem_addr_t'(`CPU_IMEM_DEPTH - 1))
          pc <= '0;
        else
          pc <= pc + imem_addr_t'(1);
      end
    end
  end

  // Instruction register seen by decode and held under stall
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      instr        <= '0; // no-op
      replay_valid <= 1'b0;
    end else if (stall) begin
      if (rd_valid) begin
        replay_valid <= 1'b1;
      end
    end else begin
      replay_valid <= 1'b0;
      if (replay_valid)
        instr <= replay;
      else if (rd_valid)
        instr <= rd_data;
      else
        instr <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (stall && rd_valid) begin
      replay <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module decode_stage (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 stall,
  input  cpu_pkg::instr_t      instr,
  output cpu_pkg::reg_idx_t    rs1,
  output cpu_pkg::reg_idx_t    rs2,
  output cpu_pkg::alu_op_t     id_op,
  output cpu_pkg::instr_kind_t id_kind,
  input  cpu_pkg::word_t       rs1_val,
  input  cpu_pkg::word_t       rs2_val,
  output cpu_pkg::alu_op_t     ex_op,
  output cpu_pkg::word_t       ex_opnd1,
  output cpu_pkg::word_t       ex_opnd2,
  output cpu_pkg::reg_idx_t    ex_dest,
  output cpu_pkg::half_en_t    ex_half_en,
  output cpu_pkg::wb_src_t     ex_src
);
  import cpu_pkg::*;

  localparam int PAD_W = `CPU_WORD_W - `CPU_IMM_W;

  logic                  imm_flag;
  logic [`CPU_IMM_W-1:0] imm;
  word_t                 imm_low;
  word_t                 imm_high;

  alu_op_t   d_op;
  word_t     d_opnd2;
  half_en_t  d_half_en;
  wb_src_t   d_src;

  assign imm_flag = instr[`CPU_IMM_FLAG_BIT];
  assign id_kind  = instr_kind_t'(instr[`CPU_KIND_MSB:`CPU_KIND_LSB]);
  assign id_op    = alu_op_t'(instr[`CPU_OP_MSB:`CPU_OP_LSB]);
  assign rs1      = instr[`CPU_RS1_MSB:`CPU_RS1_LSB]; // also the destination
  assign rs2      = instr[`CPU_RS2_MSB:`CPU_RS2_LSB];
  assign imm      = instr[`CPU_IMM_W-1:0];

  assign imm_low  = {{PAD_W{1'b0}}, imm};
  assign imm_high = {imm, {PAD_W{1'b0}}};

  always_comb begin
    // Bubble unless a real arith/move instruction
    d_op      = OP_NONE;
    d_opnd2   = rs2_val;
    d_half_en = 2'b00;
    d_src     = SRC_NONE;
    if (!stall && id_kind == KIND_ARITH_MOVE) begin
      d_op = id_op;
      case (id_op)
        OP_MOVL: begin
          d_opnd2   = imm_low;
          d_half_en = 2'b01;
          d_src     = SRC_OPND;
        end
        OP_MOVU: begin
          d_opnd2   = imm_high;
          d_half_en = 2'b10;
          d_src     = SRC_OPND;
        end
        OP_MOVR: begin
          d_opnd2   = rs2_val;
          d_half_en = 2'b11;
          d_src     = SRC_OPND;
        end
        default: begin
          // ADD, INC and unsupported ops go through the ALU
          d_opnd2   = imm_flag ? imm_low : rs2_val;
          d_half_en = 2'b11;
          d_src     = SRC_ALU;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      ex_op      <= OP_NONE;
      ex_dest    <= '0;
      ex_half_en <= 2'b00;
      ex_src     <= SRC_NONE;
    end else begin
      ex_op      <= d_op;
      ex_dest    <= rs1;
      ex_half_en <= d_half_en;
      ex_src     <= d_src;
    end
  end

  always_ff @(posedge clk) begin
    ex_opnd1 <= rs1_val;
    ex_opnd2 <= d_opnd2;
  end

endmodule

`default_nettype wire

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  cpu_pkg::reg_idx_t    rs1,
  input  cpu_pkg::reg_idx_t    rs2,
  input  cpu_pkg::alu_op_t     id_op,
  input  cpu_pkg::instr_kind_t id_kind,
  input  cpu_pkg::reg_idx_t    ex_dest,
  input  logic                 ex_writes,
  input  cpu_pkg::reg_idx_t    wb_dest,
  input  logic                 wb_writes,
  input  cpu_pkg::reg_idx_t    rf_dest,
  input  logic                 rf_writes,
  output logic                 stall
);
  import cpu_pkg::*;

  logic rs1_busy;
  logic rs2_busy;

  // Any writer still ahead of the register file commit
  assign rs1_busy = (ex_writes && ex_dest == rs1) ||
                    (wb_writes && wb_dest == rs1) ||
                    (rf_writes && rf_dest == rs1);

  assign rs2_busy = (ex_writes && ex_dest == rs2) ||
                    (wb_writes && wb_dest == rs2) ||
                    (rf_writes && rf_dest == rs2);

  always_comb begin
    stall = 1'b0;
    if (id_kind == KIND_ARITH_MOVE) begin
      if (rs1_busy)
        stall = 1'b1;
      else if (id_op != OP_INC && rs2_busy) // INC has no second source
        stall = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module reg_file (
  input  logic              clk,
  input  logic              resetn,
  input  cpu_pkg::reg_idx_t rs1,
  input  cpu_pkg::reg_idx_t rs2,
  output cpu_pkg::word_t    rs1_val,
  output cpu_pkg::word_t    rs2_val,
  input  cpu_pkg::half_en_t wr_en,
  input  cpu_pkg::reg_idx_t wr_reg,
  input  cpu_pkg::word_t    wr_data
);
  import cpu_pkg::*;

  localparam int HALF_W = `CPU_WORD_W / 2;

  word_t regs [`CPU_NUM_REGS];

  assign rs1_val = regs[rs1]; // combinational reads
  assign rs2_val = regs[rs2];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr_en[0])
        regs[wr_reg][HALF_W-1:0] <= wr_data[HALF_W-1:0];
      if (wr_en[1])
        regs[wr_reg][`CPU_WORD_W-1:HALF_W] <= wr_data[`CPU_WORD_W-1:HALF_W];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic              clk,
  input  logic              resetn,
  input  cpu_pkg::alu_op_t  ex_op,
  input  cpu_pkg::word_t    ex_opnd1,
  input  cpu_pkg::word_t    ex_opnd2,
  input  cpu_pkg::reg_idx_t ex_dest,
  input  cpu_pkg::half_en_t ex_half_en,
  input  cpu_pkg::wb_src_t  ex_src,
  output cpu_pkg::reg_idx_t wb_dest,
  output cpu_pkg::half_en_t wb_half_en,
  output cpu_pkg::wb_src_t  wb_src,
  output cpu_pkg::word_t    wb_alu,
  output cpu_pkg::word_t    wb_opnd2
);
  import cpu_pkg::*;

  word_t alu_result;

  always_comb begin
    case (ex_op)
      OP_ADD:  alu_result = ex_opnd1 + ex_opnd2;
      OP_INC:  alu_result = ex_opnd1 + word_t'(1);
      default: alu_result = '0; // moves and unsupported ops
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wb_dest    <= '0;
      wb_half_en <= 2'b00;
      wb_src     <= SRC_NONE;
    end else begin
      wb_dest    <= ex_dest;
      wb_half_en <= ex_half_en;
      wb_src     <= ex_src;
    end
  end

  always_ff @(posedge clk) begin
    wb_alu   <= alu_result;
    wb_opnd2 <= ex_opnd2;   // move value rides along
  end

endmodule

`default_nettype wire

// ==== hdl/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
  input  logic              clk,
  input  logic              resetn,
  input  cpu_pkg::reg_idx_t wb_dest,
  input  cpu_pkg::half_en_t wb_half_en,
  input  cpu_pkg::wb_src_t  wb_src,
  input  cpu_pkg::word_t    wb_alu,
  input  cpu_pkg::word_t    wb_opnd2,
  output cpu_pkg::half_en_t wr_en,
  output cpu_pkg::reg_idx_t wr_reg,
  output cpu_pkg::word_t    wr_data
);
  import cpu_pkg::*;

  word_t result;

  always_comb begin
    case (wb_src)
      SRC_ALU:  result = wb_alu;
      SRC_OPND: result = wb_opnd2;
      default:  result = '0;
    endcase
  end

  // Registered write port shared by reg file and DUT outputs
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wr_en  <= 2'b00;
      wr_reg <= '0;
    end else begin
      wr_en  <= wb_half_en;
      wr_reg <= wb_dest;
    end
  end

  always_ff @(posedge clk) begin
    wr_data <= result;
  end

endmodule

`default_nettype wire

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  logic                clk,
  input  logic                resetn,
  input  logic                run,
  input  logic                load_strobe,
  input  cpu_pkg::imem_addr_t load_addr,
  input  cpu_pkg::instr_t     load_data,
  output logic                wb_strobe,
  output cpu_pkg::reg_idx_t   wb_reg,
  output cpu_pkg::half_en_t   wb_half_en,
  output cpu_pkg::word_t      wb_data
);
  import cpu_pkg::*;

  // Fetch to decode
  instr_t      instr;
  logic        stall;

  // Decode side
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  word_t       rs1_val;
  word_t       rs2_val;
  alu_op_t     id_op;
  instr_kind_t id_kind;

  // Decode to execute
  alu_op_t     ex_op;
  word_t       ex_opnd1;
  word_t       ex_opnd2;
  reg_idx_t    ex_dest;
  half_en_t    ex_half_en;
  wb_src_t     ex_src;
  logic        ex_writes;

  // Execute to writeback
  reg_idx_t    wbs_dest;
  half_en_t    wbs_half_en;
  wb_src_t     wbs_src;
  word_t       wbs_alu;
  word_t       wbs_opnd2;
  logic        wbs_writes;

  assign ex_writes  = |ex_half_en;
  assign wbs_writes = |wbs_half_en;
  assign wb_strobe  = |wb_half_en; // one per retired write

  fetch_stage u_fetch_stage (
    .clk        (clk),
    .resetn     (resetn),
    .run        (run),
    .stall      (stall),
    .load_strobe(load_strobe),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .instr      (instr)
  );

  decode_stage u_decode_stage (
    .clk       (clk),
    .resetn    (resetn),
    .stall     (stall),
    .instr     (instr),
    .rs1       (rs1),
    .rs2       (rs2),
    .id_op     (id_op),
    .id_kind   (id_kind),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .ex_op     (ex_op),
    .ex_opnd1  (ex_opnd1),
    .ex_opnd2  (ex_opnd2),
    .ex_dest   (ex_dest),
    .ex_half_en(ex_half_en),
    .ex_src    (ex_src)
  );

  hazard_unit u_hazard_unit (
    .rs1      (rs1),
    .rs2      (rs2),
    .id_op    (id_op),
    .id_kind  (id_kind),
    .ex_dest  (ex_dest),
    .ex_writes(ex_writes),
    .wb_dest  (wbs_dest),
    .wb_writes(wbs_writes),
    .rf_dest  (wb_reg),
    .rf_writes(wb_strobe),
    .stall    (stall)
  );

  reg_file u_reg_file (
    .clk    (clk),
    .resetn (resetn),
    .rs1    (rs1),
    .rs2    (rs2),
    .rs1_val(rs1_val),
    .rs2_val(rs2_val),
    .wr_en  (wb_half_en),
    .wr_reg (wb_reg),
    .wr_data(wb_data)
  );

  execute_stage u_execute_stage (
    .clk       (clk),
    .resetn    (resetn),
    .ex_op     (ex_op),
    .ex_opnd1  (ex_opnd1),
    .ex_opnd2  (ex_opnd2),
    .ex_dest   (ex_dest),
    .ex_half_en(ex_half_en),
    .ex_src    (ex_src),
    .wb_dest   (wbs_dest),
    .wb_half_en(wbs_half_en),
    .wb_src    (wbs_src),
    .wb_alu    (wbs_alu),
    .wb_opnd2  (wbs_opnd2)
  );

  writeback_stage u_writeback_stage (
    .clk       (clk),
    .resetn    (resetn),
    .wb_dest   (wbs_dest),
    .wb_half_en(wbs_half_en),
    .wb_src    (wbs_src),
    .wb_alu    (wbs_alu),
    .wb_opnd2  (wbs_opnd2),
    .wr_en     (wb_half_en),
    .wr_reg    (wb_reg),
    .wr_data   (wb_data)
  );

endmodule

`default_nettype wire

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_tb;
  import cpu_pkg::*;

  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 3;
  localparam int CYCLES_PER_WORD = 6; // up to 3 stall cycles per word plus slack
  localparam int DRAIN_CYCLES    = 8;
  localparam int NUM_TESTS       = 6;
  localparam int HALF_W          = `CPU_WORD_W / 2;

  logic       clk;
  logic       resetn;
  logic       run;
  logic       load_strobe;
  imem_addr_t load_addr;
  instr_t     load_data;
  logic       wb_strobe;
  reg_idx_t   wb_reg;
  half_en_t   wb_half_en;
  word_t      wb_data;

  // Program of the current test padded with no-ops at load
  instr_t   prog [$];

  // Expected writes from the model in program order
  reg_idx_t exp_reg [$];
  half_en_t exp_en [$];
  word_t    exp_data [$];

  // Writes seen on the writeback port
  reg_idx_t got_reg [$];
  half_en_t got_en [$];
  word_t    got_data [$];

  int    error_count;
  int    check_count;
  string test_name;

  cpu_top u_cpu_top (
    .clk        (clk),
    .resetn     (resetn),
    .run        (run),
    .load_strobe(load_strobe),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .wb_strobe  (wb_strobe),
    .wb_reg     (wb_reg),
    .wb_half_en (wb_half_en),
    .wb_data    (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic instr_t make_instr(input logic imm_flag, input instr_kind_t kind,
                                        input alu_op_t op, input reg_idx_t rd,
                                        input reg_idx_t rs, input logic [`CPU_IMM_W-1:0] imm);
    instr_t w;
    w = '0;
    w[`CPU_IMM_FLAG_BIT]           = imm_flag;
    w[`CPU_KIND_MSB:`CPU_KIND_LSB] = kind;
    w[`CPU_OP_MSB:`CPU_OP_LSB]     = op;
    w[`CPU_RS1_MSB:`CPU_RS1_LSB]   = rd;
    w[`CPU_RS2_MSB:`CPU_RS2_LSB]   = rs;
    w[`CPU_IMM_W-1:0]              = imm;
    return w;
  endfunction

  // Register form with second operand from rs
  function automatic instr_t reg_form(input alu_op_t op, input reg_idx_t rd,
                                      input reg_idx_t rs);
    return make_instr(1'b0, KIND_ARITH_MOVE, op, rd, rs, '0);
  endfunction

  function automatic instr_t imm_form(input alu_op_t op, input reg_idx_t rd,
                                      input logic [`CPU_IMM_W-1:0] imm);
    return make_instr(1'b1, KIND_ARITH_MOVE, op, rd, '0, imm);
  endfunction

  // Reference model of the architectural write sequence
  task automatic build_expected();
    word_t                 regs [`CPU_NUM_REGS];
    instr_t                w;
    alu_op_t               op;
    reg_idx_t              rd;
    reg_idx_t              rs;
    logic [`CPU_IMM_W-1:0] imm;
    half_en_t              en;
    word_t                 data;
    exp_reg.delete();
    exp_en.delete();
    exp_data.delete();
    foreach (regs[i]) regs[i] = '0;
    foreach (prog[i]) begin
      w = prog[i];
      if (instr_kind_t'(w[`CPU_KIND_MSB:`CPU_KIND_LSB]) != KIND_ARITH_MOVE)
        continue; // no-op, memory and audio write nothing
      op  = alu_op_t'(w[`CPU_OP_MSB:`CPU_OP_LSB]);
      rd  = w[`CPU_RS1_MSB:`CPU_RS1_LSB];
      rs  = w[`CPU_RS2_MSB:`CPU_RS2_LSB];
      imm = w[`CPU_IMM_W-1:0];
      en  = 2'b11;
      case (op)
        OP_MOVL: begin
          en   = 2'b01;
          data = word_t'(imm);
        end
        OP_MOVU: begin
          en   = 2'b10;
          data = {imm, {`CPU_IMM_W{1'b0}}};
        end
        OP_MOVR: data = regs[rs];
        OP_ADD:  data = regs[rd] + (w[`CPU_IMM_FLAG_BIT] ? word_t'(imm) : regs[rs]);
        OP_INC:  data = regs[rd] + 32'd1;
        default: data = '0; // unsupported arithmetic
      endcase
      if (en[0])
        regs[rd][HALF_W-1:0] = data[HALF_W-1:0];
      if (en[1])
        regs[rd][`CPU_WORD_W-1:HALF_W] = data[`CPU_WORD_W-1:HALF_W];
      exp_reg.push_back(rd);
      exp_en.push_back(en);
      exp_data.push_back(data);
    end
  endtask

  task automatic check_reg(input reg_idx_t exp, input reg_idx_t act, input int idx);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("ERROR %s write %0d reg: expected %0d actual %0d", test_name, idx, exp, act);
    end
  endtask

  task automatic check_half_en(input half_en_t exp, input half_en_t act, input int idx);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("ERROR %s write %0d half_en: expected %b actual %b", test_name, idx, exp, act);
    end
  endtask

  task automatic check_word(input word_t exp, input word_t act, input int idx);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("ERROR %s write %0d data: expected %h actual %h", test_name, idx, exp, act);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    resetn      = 1'b0;
    run         = 1'b0;
    load_strobe = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    resetn = 1'b1;
  endtask

  task automatic load_program();
    for (int a = 0; a < `CPU_IMEM_DEPTH; a++) begin
      load_strobe = 1'b1;
      load_addr   = imem_addr_t'(a);
      load_data   = (a < prog.size()) ? prog[a] : instr_t'(0);
      @(negedge clk);
    end
    load_strobe = 1'b0;
  endtask

  task automatic sample_writeback();
    if (wb_strobe) begin
      got_reg.push_back(wb_reg);
      got_en.push_back(wb_half_en);
      got_data.push_back(wb_data);
    end
  endtask

  task automatic compare_writes();
    int n;
    n = (got_reg.size() < exp_reg.size()) ? got_reg.size() : exp_reg.size();
    for (int i = 0; i < n; i++) begin
      check_reg(exp_reg[i], got_reg[i], i);
      check_half_en(exp_en[i], got_en[i], i);
      check_word(exp_data[i], got_data[i], i);
    end
    check_count++;
    if (got_reg.size() != exp_reg.size()) begin
      error_count++;
      $display("%s: expected %0d register writes but the DUT made %0d", test_name,
               exp_reg.size(), got_reg.size());
    end
  endtask

  // Reset, load, run until the expected writes arrive or the budget runs out
  task automatic run_program(input string name);
    int budget;
    int cycles;
    int errors_before;
    test_name     = name;
    errors_before = error_count;
    build_expected();
    got_reg.delete();
    got_en.delete();
    got_data.delete();
    apply_reset();
    load_program();
    run    = 1'b1;
    budget = prog.size() * CYCLES_PER_WORD + DRAIN_CYCLES;
    cycles = 0;
    while (got_reg.size() < exp_reg.size() && cycles < budget) begin
      @(negedge clk);
      sample_writeback();
      cycles++;
    end
    run = 1'b0; // stop before the PC wraps into the program again
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      sample_writeback();
    end
    compare_writes();
    if (error_count == errors_before)
      $display("test %s: ok, %0d writes", name, got_reg.size());
    else
      $display("test %s: %0d errors", name, error_count - errors_before);
  endtask

  task automatic move_halves();
    prog.delete();
    prog.push_back(imm_form(OP_MOVL, 3'd2, 16'h1234));
    prog.push_back(imm_form(OP_MOVU, 3'd2, 16'habcd));
    prog.push_back(reg_form(OP_MOVR, 3'd3, 3'd2));
    prog.push_back(imm_form(OP_MOVL, 3'd2, 16'h5678)); // upper half kept
    prog.push_back(reg_form(OP_MOVR, 3'd4, 3'd2));
    run_program("move_halves");
  endtask

  task automatic add_chain();
    prog.delete();
    prog.push_back(imm_form(OP_MOVL, 3'd1, 16'd5));
    prog.push_back(imm_form(OP_MOVL, 3'd2, 16'd7));
    prog.push_back(reg_form(OP_ADD, 3'd1, 3'd2));
    prog.push_back(imm_form(OP_ADD, 3'd1, 16'd100));
    prog.push_back(reg_form(OP_ADD, 3'd2, 3'd1));
    prog.push_back(imm_form(OP_ADD, 3'd2, 16'h1234));
    prog.push_back(reg_form(OP_ADD, 3'd3, 3'd2));
    run_program("add_chain");
  endtask

  task automatic inc_chain();
    prog.delete();
    prog.push_back(imm_form(OP_MOVL, 3'd3, 16'hfffe));
    repeat (5) prog.push_back(reg_form(OP_INC, 3'd3, 3'd0)); // carries into upper half
    run_program("inc_chain");
  endtask

  task automatic move_reg_unsupported();
    prog.delete();
    prog.push_back(imm_form(OP_MOVL, 3'd4, 16'hbeef));
    prog.push_back(imm_form(OP_MOVU, 3'd4, 16'hdead));
    prog.push_back(reg_form(OP_MOVR, 3'd5, 3'd4));
    prog.push_back(reg_form(alu_op_t'(3'b010), 3'd6, 3'd5));
    prog.push_back(imm_form(alu_op_t'(3'b100), 3'd5, 16'h0042));
    prog.push_back(reg_form(OP_NONE, 3'd7, 3'd4));
    run_program("move_reg_unsupported");
  endtask

  task automatic no_write_types();
    prog.delete();
    prog.push_back(imm_form(OP_MOVL, 3'd1, 16'h00aa));
    prog.push_back(make_instr(1'b1, KIND_NONE, OP_ADD, 3'd1, 3'd2, 16'hffff));
    prog.push_back(make_instr(1'b0, KIND_MEMORY, OP_MOVL, 3'd1, 3'd0, 16'h5555));
    prog.push_back(make_instr(1'b0, KIND_AUDIO, OP_INC, 3'd1, 3'd1, 16'h0000));
    prog.push_back(imm_form(OP_MOVU, 3'd1, 16'h00bb));
    prog.push_back(reg_form(OP_INC, 3'd1, 3'd0));
    run_program("no_write_types");
  endtask

  task automatic random_program();
    alu_op_t ops [5] = '{OP_ADD, OP_INC, OP_MOVL, OP_MOVU, OP_MOVR};
    alu_op_t op;
    logic    flag;
    prog.delete();
    for (int i = 0; i < 40; i++) begin
      op   = ops[$urandom_range(4, 0)];
      flag = 1'($urandom_range(1, 0));
      prog.push_back(make_instr(flag, KIND_ARITH_MOVE, op,
                                reg_idx_t'($urandom_range(7, 0)),
                                reg_idx_t'($urandom_range(7, 0)),
                                16'($urandom())));
    end
    run_program("random_program");
  endtask

  // Watchdog sized from test count, memory depth and per-word budget
  initial begin
    #(NUM_TESTS * `CPU_IMEM_DEPTH * CYCLES_PER_WORD * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("Checks failed");
    $finish;
  end

  initial begin
    void'($urandom(12));
    resetn      = 1'b0;
    run         = 1'b0;
    load_strobe = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    error_count = 0;
    check_count = 0;
    move_halves();
    add_chain();
    inc_chain();
    move_reg_unsupported();
    no_write_types();
    random_program();
    $display("tests: %0d  checks: %0d  errors: %0d", NUM_TESTS, check_count, error_count);
    if (error_count == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/instr_memory.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/hazard_unit.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/cpu_top.sv
verif/cpu_tb.sv

// ==== Makefile ====
# Verilator build and run for the pipeline testbench

TOP := cpu_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f \
		--Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
